/* design/capability_decoder.sv */
`include "training_macros.svh"

module capability_decoder
    import link_gen_pkg::*;
    import lane_state_pkg::*;
(
    input  logic         fsm_clk,
    input  logic         reset_n,
    input  train_state_t state_i,
    input  logic [31:0]  c_data_in_i,
    input  logic [23:0]  payload_in_i,
    input  logic         t_valid_i,
    output logic         usb4_detected_o,
    output link_gen_t    gen_speed_o
);

    link_gen_t cable_gen_d;
    link_gen_t peer_gen_d;
    link_gen_t cable_gen_q;
    link_gen_t peer_gen_q;
    link_gen_t gen_speed_q;
    logic      usb4_q;

    // Highest generation advertised wins
    always_comb begin
        if (c_data_in_i[`CABLE_GEN4_BIT]) begin
            cable_gen_d = GEN4;
        end else if (c_data_in_i[`CABLE_GEN3_BIT]) begin
            cable_gen_d = GEN3;
        end else begin
            cable_gen_d = GEN2;
        end

        if (payload_in_i[`PEER_GEN4_BIT]) begin
            peer_gen_d = GEN4;
        end else if (payload_in_i[`PEER_GEN3_BIT]) begin
            peer_gen_d = GEN3;
        end else begin
            peer_gen_d = GEN2;
        end
    end

    always_ff @(posedge fsm_clk or negedge reset_n) begin
        if (!reset_n) begin
            usb4_q      <= 1'b0;
            cable_gen_q <= GEN4;
            peer_gen_q  <= GEN4;
            gen_speed_q <= GEN4;
        end else if (state_i == DISABLED) begin
            usb4_q      <= 1'b0;
            cable_gen_q <= GEN4;
            peer_gen_q  <= GEN4;
            gen_speed_q <= GEN4;
        end else begin
            // Register word is sampled every cycle of the cable read
            if (state_i == CLD_CABLE) begin
                usb4_q      <= (c_data_in_i[7:0] == `USB4_CABLE_ID);
                cable_gen_q <= cable_gen_d;
            end
            if (state_i == CLD_EXCHANGE_1 && t_valid_i) begin
                peer_gen_q <= peer_gen_d;
            end
            // Negotiated speed is the slower side
            if (cable_gen_q > peer_gen_q) begin
                gen_speed_q <= cable_gen_q;
            end else begin
                gen_speed_q <= peer_gen_q;
            end
        end
    end

    assign usb4_detected_o = usb4_q;
    assign gen_speed_o     = gen_speed_q;

endmodule

/* design/lane_control_top.sv */
module lane_control_top
    import link_gen_pkg::*;
    import lane_state_pkg::*;
(
    input  logic        fsm_clk,
    input  logic        reset_n,
    input  logic [31:0] c_data_in_i,
    input  logic [23:0] payload_in_i,
    input  logic        t_valid_i,
    input  logic        lane_disable_i,
    input  logic        tdisabled_min_i,
    input  logic        disconnect_sbrx_i,
    input  logic        tgen4_ts1_timeout_i,
    input  logic        tgen4_ts2_timeout_i,
    input  logic        ttraining_error_timeout_i,
    input  logic        trans_sent_i,
    input  logic        new_sym_i,
    input  logic        os_sent_i,
    input  logic [3:0]  os_in_l0_i,
    input  logic [3:0]  os_in_l1_i,
    output lane_sel_t   d_sel_o,
    output link_gen_t   gen_speed_o,
    output logic        c_read_o,
    output logic [7:0]  c_address_o,
    output logic        fsm_disabled_o,
    output logic        fsm_training_o,
    output logic        ts1_gen4_s_o,
    output logic        ts2_gen4_s_o
);

    train_state_t state;
    train_state_t next_state;
    link_gen_t    gen_speed;
    logic         usb4_detected;
    logic         os_done;

    capability_decoder u_decoder (
        .fsm_clk         (fsm_clk),
        .reset_n         (reset_n),
        .state_i         (state),
        .c_data_in_i     (c_data_in_i),
        .payload_in_i    (payload_in_i),
        .t_valid_i       (t_valid_i),
        .usb4_detected_o (usb4_detected),
        .gen_speed_o     (gen_speed)
    );

    training_sequencer u_sequencer (
        .fsm_clk                   (fsm_clk),
        .reset_n                   (reset_n),
        .lane_disable_i            (lane_disable_i),
        .tdisabled_min_i           (tdisabled_min_i),
        .disconnect_sbrx_i         (disconnect_sbrx_i),
        .tgen4_ts1_timeout_i       (tgen4_ts1_timeout_i),
        .tgen4_ts2_timeout_i       (tgen4_ts2_timeout_i),
        .ttraining_error_timeout_i (ttraining_error_timeout_i),
        .t_valid_i                 (t_valid_i),
        .trans_sent_i              (trans_sent_i),
        .new_sym_i                 (new_sym_i),
        .usb4_detected_i           (usb4_detected),
        .gen_speed_i               (gen_speed),
        .os_done_i                 (os_done),
        .state_o                   (state),
        .next_state_o              (next_state)
    );

    os_counter u_counter (
        .fsm_clk      (fsm_clk),
        .reset_n      (reset_n),
        .state_i      (state),
        .next_state_i (next_state),
        .gen_speed_i  (gen_speed),
        .os_sent_i    (os_sent_i),
        .os_in_l0_i   (os_in_l0_i),
        .os_in_l1_i   (os_in_l1_i),
        .os_done_o    (os_done)
    );

    lane_output_encoder u_encoder (
        .fsm_clk        (fsm_clk),
        .reset_n        (reset_n),
        .next_state_i   (next_state),
        .gen_speed_i    (gen_speed),
        .d_sel_o        (d_sel_o),
        .gen_speed_o    (gen_speed_o),
        .c_read_o       (c_read_o),
        .c_address_o    (c_address_o),
        .fsm_disabled_o (fsm_disabled_o),
        .fsm_training_o (fsm_training_o),
        .ts1_gen4_s_o   (ts1_gen4_s_o),
        .ts2_gen4_s_o   (ts2_gen4_s_o)
    );

endmodule

/* design/lane_output_encoder.sv */
`include "training_macros.svh"

module lane_output_encoder
    import link_gen_pkg::*;
    import lane_state_pkg::*;
(
    input  logic         fsm_clk,
    input  logic         reset_n,
    input  train_state_t next_state_i,
    input  link_gen_t    gen_speed_i,
    output lane_sel_t    d_sel_o,
    output link_gen_t    gen_speed_o,
    output logic         c_read_o,
    output logic [7:0]   c_address_o,
    output logic         fsm_disabled_o,
    output logic         fsm_training_o,
    output logic         ts1_gen4_s_o,
    output logic         ts2_gen4_s_o
);

    localparam logic [7:0] CABLE_ADDR = 8'(`CABLE_REG_ADDR);

    lane_sel_t sel_d;
    logic      in_training;
    logic      in_setup;

    // Exchange 1 drives SLOS1 on the lanes while parameters are traded
    always_comb begin
        case (next_state_i)
            CLD_EXCHANGE_1, SLOS1_GEN3: sel_d = SEL_SLOS1;
            SLOS2_GEN3: sel_d = SEL_SLOS2;
            TS1_GEN3:   sel_d = SEL_TS1_G3;
            TS2_GEN3:   sel_d = SEL_TS2_G3;
            TS1_GEN4:   sel_d = SEL_TS1_G4;
            TS2_GEN4:   sel_d = SEL_TS2_G4;
            TS3_GEN4:   sel_d = SEL_TS3_G4;
            TS4_GEN4:   sel_d = SEL_TS4_G4;
            CL0:        sel_d = SEL_DATA;
            default:    sel_d = SEL_ZEROS;
        endcase
    end

    assign in_training = is_training_state(next_state_i);
    // CL0 keeps the flags it arrived with
    assign in_setup    = !in_training && (next_state_i != CL0);

    always_ff @(posedge fsm_clk or negedge reset_n) begin
        if (!reset_n) begin
            d_sel_o        <= SEL_ZEROS;
            gen_speed_o    <= GEN4;
            c_read_o       <= 1'b0;
            c_address_o    <= '0;
            fsm_disabled_o <= 1'b1;
            fsm_training_o <= 1'b0;
            ts1_gen4_s_o   <= 1'b0;
            ts2_gen4_s_o   <= 1'b0;
        end else begin
            d_sel_o        <= sel_d;
            gen_speed_o    <= gen_speed_i;
            c_read_o       <= (next_state_i == CLD_CABLE);
            c_address_o    <= (next_state_i == CLD_CABLE) ? CABLE_ADDR : '0;
            fsm_disabled_o <= (next_state_i == DISABLED);
            if (in_training) begin
                fsm_training_o <= 1'b1;
            end else if (in_setup) begin
                fsm_training_o <= 1'b0;
            end
            if (next_state_i == TS1_GEN4) begin
                ts1_gen4_s_o <= 1'b1;
            end else if (in_setup) begin
                ts1_gen4_s_o <= 1'b0;
            end
            if (next_state_i == TS2_GEN4) begin
                ts2_gen4_s_o <= 1'b1;
            end else if (in_setup) begin
                ts2_gen4_s_o <= 1'b0;
            end
        end
    end

endmodule

/* design/lane_state_pkg.sv */
package lane_state_pkg;

    typedef enum logic [3:0] {
        DISABLED       = 4'd0,
        CLD_CABLE      = 4'd1,
        CLD_DETECT     = 4'd2,
        CLD_EXCHANGE_1 = 4'd3,
        CLD_EXCHANGE_2 = 4'd4,
        CLD_CLOCK      = 4'd5,
        TS1_GEN4       = 4'd6,
        TS2_GEN4       = 4'd7,
        TS3_GEN4       = 4'd8,
        TS4_GEN4       = 4'd9,
        SLOS1_GEN3     = 4'd10,
        SLOS2_GEN3     = 4'd11,
        TS1_GEN3       = 4'd12,
        TS2_GEN3       = 4'd13,
        CL0            = 4'd14
    } train_state_t;

    // Lane data select whose values 0 to 7 follow the ordered-set codes
    typedef enum logic [3:0] {
        SEL_SLOS1  = 4'd0,
        SEL_SLOS2  = 4'd1,
        SEL_TS1_G3 = 4'd2,
        SEL_TS2_G3 = 4'd3,
        SEL_TS1_G4 = 4'd4,
        SEL_TS2_G4 = 4'd5,
        SEL_TS3_G4 = 4'd6,
        SEL_TS4_G4 = 4'd7,
        SEL_DATA   = 4'd8,
        SEL_ZEROS  = 4'd9
    } lane_sel_t;

    // States that exchange ordered sets on the lanes
    function automatic logic is_training_state(train_state_t s);
        return s inside {TS1_GEN4, TS2_GEN4, TS3_GEN4, TS4_GEN4,
                         SLOS1_GEN3, SLOS2_GEN3, TS1_GEN3, TS2_GEN3};
    endfunction

endpackage

/* design/link_gen_pkg.sv */
package link_gen_pkg;

    // Link generation where a larger value is a slower link
    typedef enum logic [1:0] {
        GEN4 = 2'd0,
        GEN3 = 2'd1,
        GEN2 = 2'd2
    } link_gen_t;

    // Ordered-set code reported per lane by the receiver
    typedef enum logic [3:0] {
        SLOS1  = 4'd0,
        SLOS2  = 4'd1,
        TS1_G3 = 4'd2,
        TS2_G3 = 4'd3,
        TS1_G4 = 4'd4,
        TS2_G4 = 4'd5,
        TS3_G4 = 4'd6,
        TS4_G4 = 4'd7
    } os_code_t;

endpackage

/* design/os_counter.sv */
`include "training_macros.svh"

module os_counter
    import link_gen_pkg::*;
    import lane_state_pkg::*;
(
    input  logic         fsm_clk,
    input  logic         reset_n,
    input  train_state_t state_i,
    input  train_state_t next_state_i,
    input  link_gen_t    gen_speed_i,
    input  logic         os_sent_i,
    input  logic [3:0]   os_in_l0_i,
    input  logic [3:0]   os_in_l1_i,
    output logic         os_done_o
);

    typedef logic [`OS_CNT_W-1:0] cnt_t;

    os_code_t        exp_code;
    cnt_t            sent_tgt;
    cnt_t            recv_tgt;
    cnt_t            sent_cnt;
    cnt_t [1:0]      recv_cnt;
    logic [1:0][3:0] lane_code;
    logic            counting;

    assign lane_code = {os_in_l1_i, os_in_l0_i};
    assign counting  = (next_state_i == state_i) && is_training_state(state_i);

    always_comb begin
        case (state_i)
            SLOS2_GEN3: exp_code = SLOS2;
            TS1_GEN3:   exp_code = TS1_G3;
            TS2_GEN3:   exp_code = TS2_G3;
            TS1_GEN4:   exp_code = TS1_G4;
            TS2_GEN4:   exp_code = TS2_G4;
            TS3_GEN4:   exp_code = TS3_G4;
            TS4_GEN4:   exp_code = TS4_G4;
            default:    exp_code = SLOS1;
        endcase
    end

    // Gen3 TS states double their sent target at Gen2
    always_comb begin
        recv_tgt = cnt_t'(`OS_RECV_G3);
        case (state_i)
            TS1_GEN4, TS2_GEN4, TS3_GEN4, TS4_GEN4: begin
                sent_tgt = cnt_t'(`OS_SENT_G4);
                recv_tgt = cnt_t'(`OS_RECV_G4);
            end
            SLOS1_GEN3, SLOS2_GEN3: sent_tgt = cnt_t'(`OS_SENT_SLOS);
            TS1_GEN3: begin
                sent_tgt = (gen_speed_i == GEN2) ? cnt_t'(`OS_SENT_TS1_G2)
                                                 : cnt_t'(`OS_SENT_TS1_G3);
            end
            TS2_GEN3: begin
                sent_tgt = (gen_speed_i == GEN2) ? cnt_t'(`OS_SENT_TS2_G2)
                                                 : cnt_t'(`OS_SENT_TS2_G3);
            end
            default: sent_tgt = '0;
        endcase
    end

    always_ff @(posedge fsm_clk or negedge reset_n) begin
        if (!reset_n) begin
            sent_cnt <= '0;
            recv_cnt <= '0;
        end else if (!counting) begin
            // Fresh count for every state
            sent_cnt <= '0;
            recv_cnt <= '0;
        end else begin
            if (os_sent_i && sent_cnt < sent_tgt) begin
                sent_cnt <= sent_cnt + 1'b1;
            end
            for (int lane = 0; lane < 2; lane++) begin
                // Saturate so surplus sets cannot stall the step
                if (lane_code[lane] == exp_code && recv_cnt[lane] < recv_tgt) begin
                    recv_cnt[lane] <= recv_cnt[lane] + 1'b1;
                end
            end
        end
    end

    assign os_done_o = is_training_state(state_i) && (sent_cnt == sent_tgt)
                       && (recv_cnt[0] == recv_tgt) && (recv_cnt[1] == recv_tgt);

endmodule

/* design/training_macros.svh */
`ifndef TRAINING_MACROS_SVH
`define TRAINING_MACROS_SVH

// Ordered-set counter width covers the largest target
`define OS_CNT_W 6

// Gen4 targets for each TS state
`define OS_SENT_G4 16
`define OS_RECV_G4 1

// SLOS1 and SLOS2 for Gen3 and Gen2
`define OS_SENT_SLOS 2
`define OS_RECV_G3 2

// TS1 and TS2 sent targets at Gen3
`define OS_SENT_TS1_G3 16
`define OS_SENT_TS2_G3 8

// Gen2 sends twice as many
`define OS_SENT_TS1_G2 32
`define OS_SENT_TS2_G2 16

// Cable capability register and the identity byte in bits 7:0
`define CABLE_REG_ADDR 18
`define USB4_CABLE_ID 8'h40

// Generation support bits
`define CABLE_GEN4_BIT 21
`define CABLE_GEN3_BIT 20
`define PEER_GEN4_BIT 18
`define PEER_GEN3_BIT 13

`endif

/* design/training_sequencer.sv */
module training_sequencer
    import link_gen_pkg::*;
    import lane_state_pkg::*;
(
    input  logic         fsm_clk,
    input  logic         reset_n,
    input  logic         lane_disable_i,
    input  logic         tdisabled_min_i,
    input  logic         disconnect_sbrx_i,
    input  logic         tgen4_ts1_timeout_i,
    input  logic         tgen4_ts2_timeout_i,
    input  logic         ttraining_error_timeout_i,
    input  logic         t_valid_i,
    input  logic         trans_sent_i,
    input  logic         new_sym_i,
    input  logic         usb4_detected_i,
    input  link_gen_t    gen_speed_i,
    input  logic         os_done_i,
    output train_state_t state_o,
    output train_state_t next_state_o
);

    train_state_t state_q;
    train_state_t step_state;
    train_state_t next_state;
    logic         linked;
    logic         timeout;

    always_ff @(posedge fsm_clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= DISABLED;
        end else begin
            state_q <= next_state;
        end
    end

    // Sideband is up once detect has passed
    assign linked = !(state_q inside {DISABLED, CLD_CABLE, CLD_DETECT});

    always_comb begin
        timeout = ttraining_error_timeout_i && is_training_state(state_q);
        // Gen4 TS1 and TS2 have their own timers as well
        if (state_q == TS1_GEN4) begin
            timeout = timeout || tgen4_ts1_timeout_i;
        end
        if (state_q == TS2_GEN4) begin
            timeout = timeout || tgen4_ts2_timeout_i;
        end
    end

    // Forward progress of each state, before any return path
    always_comb begin
        step_state = state_q;
        case (state_q)
            DISABLED: begin
                if (tdisabled_min_i) begin
                    step_state = CLD_CABLE;
                end
            end
            CLD_CABLE: begin
                if (usb4_detected_i) begin
                    step_state = CLD_DETECT;
                end
            end
            CLD_DETECT: begin
                if (!disconnect_sbrx_i) begin
                    step_state = CLD_EXCHANGE_1;
                end
            end
            CLD_EXCHANGE_1: begin
                if (t_valid_i) begin
                    step_state = CLD_EXCHANGE_2;
                end
            end
            CLD_EXCHANGE_2: begin
                if (trans_sent_i) begin
                    step_state = CLD_CLOCK;
                end
            end
            CLD_CLOCK: begin
                // Gen3 and Gen2 share the SLOS path
                if (new_sym_i) begin
                    step_state = (gen_speed_i == GEN4) ? TS1_GEN4 : SLOS1_GEN3;
                end
            end
            TS1_GEN4: begin
                if (os_done_i) begin
                    step_state = TS2_GEN4;
                end
            end
            TS2_GEN4: begin
                if (os_done_i) begin
                    step_state = TS3_GEN4;
                end
            end
            TS3_GEN4: begin
                if (os_done_i) begin
                    step_state = TS4_GEN4;
                end
            end
            SLOS1_GEN3: begin
                if (os_done_i) begin
                    step_state = SLOS2_GEN3;
                end
            end
            SLOS2_GEN3: begin
                if (os_done_i) begin
                    step_state = TS1_GEN3;
                end
            end
            TS1_GEN3: begin
                if (os_done_i) begin
                    step_state = TS2_GEN3;
                end
            end
            // Last step lands on a symbol boundary
            TS4_GEN4, TS2_GEN3: begin
                if (os_done_i && new_sym_i) begin
                    step_state = CL0;
                end
            end
            CL0: step_state = CL0;
            default: step_state = DISABLED;
        endcase
    end

    // Disable beats disconnect, disconnect beats timeout
    always_comb begin
        if (lane_disable_i) begin
            next_state = DISABLED;
        end else if (disconnect_sbrx_i && linked) begin
            next_state = CLD_DETECT;
        end else if (timeout) begin
            next_state = CLD_EXCHANGE_1;
        end else begin
            next_state = step_state;
        end
    end

    assign state_o      = state_q;
    assign next_state_o = next_state;

endmodule

/* project.f */
+incdir+design
design/link_gen_pkg.sv
design/lane_state_pkg.sv
design/capability_decoder.sv
design/training_sequencer.sv
design/os_counter.sv
design/lane_output_encoder.sv
design/lane_control_top.sv
test/lane_control_assert.sv
test/lane_control_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f project.f \
    --top-module lane_control_tb \
    -o lane_control_sim

output="$(./obj_dir/lane_control_sim 2>&1)" || {
    echo "$output"
    exit 1
}
echo "$output"

if grep -qx "RESULT: PASS" <<< "$output"; then
    exit 0
fi
exit 1

/* test/lane_control_assert.sv */
module lane_control_assert
    import lane_state_pkg::*;
(
    input logic      fsm_clk,
    input logic      reset_n,
    input lane_sel_t d_sel_o,
    input logic      c_read_o,
    input logic      fsm_disabled_o,
    input logic      fsm_training_o
);

    // Only ten select codes exist
    sel_in_range: assert property (@(posedge fsm_clk) disable iff (!reset_n)
        d_sel_o <= SEL_ZEROS)
        else $error("lane select above the last code");

    // Disabled and training are exclusive
    flags_exclusive: assert property (@(posedge fsm_clk) disable iff (!reset_n)
        !(fsm_disabled_o && fsm_training_o))
        else $error("disabled and training flags high together");

    // Cable read happens before the lanes carry anything
    read_on_idle_lanes: assert property (@(posedge fsm_clk) disable iff (!reset_n)
        c_read_o |-> (d_sel_o == SEL_ZEROS))
        else $error("cable read while lanes are not idle");

endmodule

bind lane_control_top lane_control_assert u_assert (
    .fsm_clk        (fsm_clk),
    .reset_n        (reset_n),
    .d_sel_o        (d_sel_o),
    .c_read_o       (c_read_o),
    .fsm_disabled_o (fsm_disabled_o),
    .fsm_training_o (fsm_training_o)
);

/* test/lane_control_tb.sv */
`include "training_macros.svh"

module lane_control_tb
    import link_gen_pkg::*;
    import lane_state_pkg::*;
();

    localparam int         NUM_ROWS      = 7;
    localparam int         WAIT_LIMIT    = 80;
    localparam int         WATCHDOG_TIME = NUM_ROWS * 300 * 8;
    localparam logic [3:0] IDLE_CODE     = 4'hF;
    localparam int         EV_NONE       = 0;
    localparam int         EV_TIMEOUT    = 1;
    localparam int         EV_DISCONNECT = 2;
    localparam int         EV_DISABLE    = 3;

    logic        fsm_clk;
    logic        reset_n;
    logic [31:0] c_data_in;
    logic [23:0] payload_in;
    logic        t_valid;
    logic        lane_disable;
    logic        tdisabled_min;
    logic        disconnect_sbrx;
    logic        tgen4_ts1_timeout;
    logic        tgen4_ts2_timeout;
    logic        ttraining_error_timeout;
    logic        trans_sent;
    logic        new_sym;
    logic        os_sent;
    logic [3:0]  os_in_l0;
    logic [3:0]  os_in_l1;
    lane_sel_t   d_sel;
    link_gen_t   gen_speed;
    logic        c_read;
    logic [7:0]  c_address;
    logic        fsm_disabled;
    logic        fsm_training;
    logic        ts1_gen4_s;
    logic        ts2_gen4_s;

    // Stimulus table with the training selects packed four bits per step from the top
    string       row_name    [NUM_ROWS];
    logic [31:0] row_cable   [NUM_ROWS];
    logic [23:0] row_payload [NUM_ROWS];
    int          row_event   [NUM_ROWS];
    link_gen_t   row_gen     [NUM_ROWS];
    int          row_steps   [NUM_ROWS];
    logic [15:0] row_sels    [NUM_ROWS];
    logic [3:0]  row_final   [NUM_ROWS];

    logic [31:0] lfsr;
    string       cur_test;
    int          error_count;
    int          test_errors;
    int          tests_failed;

    lane_control_top dut0 (
        .fsm_clk                   (fsm_clk),
        .reset_n                   (reset_n),
        .c_data_in_i               (c_data_in),
        .payload_in_i              (payload_in),
        .t_valid_i                 (t_valid),
        .lane_disable_i            (lane_disable),
        .tdisabled_min_i           (tdisabled_min),
        .disconnect_sbrx_i         (disconnect_sbrx),
        .tgen4_ts1_timeout_i       (tgen4_ts1_timeout),
        .tgen4_ts2_timeout_i       (tgen4_ts2_timeout),
        .ttraining_error_timeout_i (ttraining_error_timeout),
        .trans_sent_i              (trans_sent),
        .new_sym_i                 (new_sym),
        .os_sent_i                 (os_sent),
        .os_in_l0_i                (os_in_l0),
        .os_in_l1_i                (os_in_l1),
        .d_sel_o                   (d_sel),
        .gen_speed_o               (gen_speed),
        .c_read_o                  (c_read),
        .c_address_o               (c_address),
        .fsm_disabled_o            (fsm_disabled),
        .fsm_training_o            (fsm_training),
        .ts1_gen4_s_o              (ts1_gen4_s),
        .ts2_gen4_s_o              (ts2_gen4_s)
    );

    initial fsm_clk = 1'b0;
    always #4 fsm_clk = ~fsm_clk;

    task automatic load_row(input int r, input string name, input logic [31:0] cable,
                            input logic [23:0] payload, input int ev, input link_gen_t gen,
                            input int steps, input logic [15:0] sels,
                            input logic [3:0] final_sel);
        row_name[r]    = name;
        row_cable[r]   = cable;
        row_payload[r] = payload;
        row_event[r]   = ev;
        row_gen[r]     = gen;
        row_steps[r]   = steps;
        row_sels[r]    = sels;
        row_final[r]   = final_sel;
    endtask

    task automatic load_table();
        load_row(0, "bad_cable", 32'h0030_0041, 24'h04_2000, EV_NONE, GEN4, 0,
                 16'h0000, SEL_ZEROS);
        load_row(1, "gen4_full", 32'h0030_0040, 24'h04_2000, EV_NONE, GEN4, 4,
                 16'h4567, SEL_DATA);
        load_row(2, "gen3_cable", 32'h0010_0040, 24'h04_2000, EV_NONE, GEN3, 4,
                 16'h0123, SEL_DATA);
        load_row(3, "gen2_peer", 32'h0030_0040, 24'h00_0000, EV_NONE, GEN2, 4,
                 16'h0123, SEL_DATA);
        load_row(4, "ts1_timeout", 32'h0030_0040, 24'h04_2000, EV_TIMEOUT, GEN4, 1,
                 16'h4000, SEL_SLOS1);
        load_row(5, "cl0_disconnect", 32'h0030_0040, 24'h04_2000, EV_DISCONNECT, GEN4, 4,
                 16'h4567, SEL_ZEROS);
        load_row(6, "cl0_disable", 32'h0000_0040, 24'h04_2000, EV_DISABLE, GEN2, 4,
                 16'h0123, SEL_ZEROS);
    endtask

    task automatic tick();
        @(posedge fsm_clk);
        #1;
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: %s %s expected %0h actual %0h", cur_test, what,
                     expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic wait_for_sel(input logic [3:0] target);
        int n;
        n = 0;
        while (d_sel != target && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
    endtask

    task automatic wait_for_read(input logic level);
        int n;
        n = 0;
        while (c_read != level && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic draw_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic int sent_target(input logic [3:0] sel, input link_gen_t gen);
        case (sel)
            SEL_SLOS1, SEL_SLOS2: sent_target = `OS_SENT_SLOS;
            SEL_TS1_G3: sent_target = (gen == GEN2) ? `OS_SENT_TS1_G2 : `OS_SENT_TS1_G3;
            SEL_TS2_G3: sent_target = (gen == GEN2) ? `OS_SENT_TS2_G2 : `OS_SENT_TS2_G3;
            default:    sent_target = `OS_SENT_G4;
        endcase
    endfunction

    function automatic int recv_target(input logic [3:0] sel);
        recv_target = (sel >= SEL_TS1_G4) ? `OS_RECV_G4 : `OS_RECV_G3;
    endfunction

    // Sends the sets of one training step, each received set on both lanes
    task automatic run_step(input logic [3:0] sel, input link_gen_t gen, input logic last);
        int   sent;
        int   recv;
        int   cycles;
        int   i;
        logic first_lane;
        logic lane;
        sent       = sent_target(sel, gen);
        recv       = recv_target(sel);
        cycles     = (sent > 2 * recv) ? sent : 2 * recv;
        first_lane = 1'b0;
        for (i = 0; i < cycles; i++) begin
            os_sent  = (i < sent);
            os_in_l0 = IDLE_CODE;
            os_in_l1 = IDLE_CODE;
            if (i < 2 * recv) begin
                if (i[0] == 1'b0) begin
                    first_lane = draw_bit();
                end
                lane = first_lane ^ i[0];
                // Select values 0 to 7 equal the ordered-set codes
                if (lane) begin
                    os_in_l1 = sel;
                end else begin
                    os_in_l0 = sel;
                end
            end
            tick();
        end
        os_sent  = 1'b0;
        os_in_l0 = IDLE_CODE;
        os_in_l1 = IDLE_CODE;
        if (last) begin
            new_sym = 1'b1;
            tick();
            new_sym = 1'b0;
        end
    endtask

    task automatic run_row(input int r);
        int         k;
        logic [3:0] sel;
        logic       gen4_link;
        c_data_in       = row_cable[r];
        payload_in      = row_payload[r];
        disconnect_sbrx = 1'b1;
        tdisabled_min   = 1'b1;
        wait_for_read(1'b1);
        check_value("c_read", 32'(1), 32'(c_read));
        check_value("c_address", `CABLE_REG_ADDR, 32'(c_address));
        tdisabled_min = 1'b0;
        if (row_cable[r][7:0] != `USB4_CABLE_ID) begin
            repeat (10) tick();
            check_value("c_read held", 32'(1), 32'(c_read));
            check_value("fsm_training", 32'(0), 32'(fsm_training));
        end else begin
            wait_for_read(1'b0);
            check_value("d_sel detect", 32'(SEL_ZEROS), 32'(d_sel));
            check_value("fsm_disabled", 32'(0), 32'(fsm_disabled));
            disconnect_sbrx = 1'b0;
            wait_for_sel(SEL_SLOS1);
            check_value("d_sel exchange 1", 32'(SEL_SLOS1), 32'(d_sel));
            t_valid = 1'b1;
            tick();
            t_valid = 1'b0;
            check_value("d_sel exchange 2", 32'(SEL_ZEROS), 32'(d_sel));
            trans_sent = 1'b1;
            tick();
            trans_sent = 1'b0;
            new_sym = 1'b1;
            tick();
            new_sym = 1'b0;
            for (k = 0; k < row_steps[r]; k++) begin
                sel = row_sels[r][15 - 4 * k -: 4];
                wait_for_sel(sel);
                check_value("d_sel training", 32'(sel), 32'(d_sel));
                check_value("fsm_training", 32'(1), 32'(fsm_training));
                if (k == 0) begin
                    check_value("gen_speed", 32'(row_gen[r]), 32'(gen_speed));
                end
                if (row_event[r] == EV_TIMEOUT) begin
                    ttraining_error_timeout = 1'b1;
                    tick();
                    ttraining_error_timeout = 1'b0;
                end else begin
                    run_step(sel, row_gen[r], k == row_steps[r] - 1);
                end
            end
            // Events injected once the link reaches CL0
            if (row_event[r] == EV_DISCONNECT || row_event[r] == EV_DISABLE) begin
                wait_for_sel(SEL_DATA);
                check_value("d_sel cl0", 32'(SEL_DATA), 32'(d_sel));
                disconnect_sbrx = (row_event[r] == EV_DISCONNECT);
                lane_disable    = (row_event[r] == EV_DISABLE);
                tick();
            end
        end
        wait_for_sel(row_final[r]);
        check_value("d_sel final", 32'(row_final[r]), 32'(d_sel));
        // Only a Gen4 link that went through training sets the TS flags
        gen4_link = (row_gen[r] == GEN4) && (row_steps[r] != 0);
        case (row_event[r])
            EV_NONE: begin
                check_value("ts1_gen4_s", 32'(gen4_link), 32'(ts1_gen4_s));
                check_value("ts2_gen4_s", 32'(gen4_link), 32'(ts2_gen4_s));
            end
            EV_TIMEOUT: begin
                check_value("fsm_training", 32'(0), 32'(fsm_training));
                check_value("ts1_gen4_s", 32'(0), 32'(ts1_gen4_s));
            end
            EV_DISCONNECT: check_value("fsm_training", 32'(0), 32'(fsm_training));
            default: check_value("fsm_disabled", 32'(1), 32'(fsm_disabled));
        endcase
    endtask

    task automatic return_to_disabled();
        lane_disable    = 1'b1;
        tdisabled_min   = 1'b0;
        disconnect_sbrx = 1'b0;
        c_data_in       = '0;
        payload_in      = '0;
        tick();
        tick();
        lane_disable = 1'b0;
        check_value("fsm_disabled after disable", 32'(1), 32'(fsm_disabled));
    endtask

    task automatic report_test();
        if (test_errors == 0) begin
            $display("%s: passed", cur_test);
        end else begin
            $display("%s: failed with %0d errors", cur_test, test_errors);
            tests_failed++;
        end
    endtask

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: the tests did not finish within %0d time units", WATCHDOG_TIME);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        reset_n                 = 1'b0;
        c_data_in               = '0;
        payload_in              = '0;
        t_valid                 = 1'b0;
        lane_disable            = 1'b0;
        tdisabled_min           = 1'b0;
        disconnect_sbrx         = 1'b0;
        tgen4_ts1_timeout       = 1'b0;
        tgen4_ts2_timeout       = 1'b0;
        ttraining_error_timeout = 1'b0;
        trans_sent              = 1'b0;
        new_sym                 = 1'b0;
        os_sent                 = 1'b0;
        os_in_l0                = IDLE_CODE;
        os_in_l1                = IDLE_CODE;
        lfsr                    = 32'h0c2a_1995;
        error_count             = 0;
        tests_failed            = 0;
        load_table();

        cur_test    = "reset";
        test_errors = 0;
        repeat (4) @(posedge fsm_clk);
        #1;
        check_value("d_sel", 32'(SEL_ZEROS), 32'(d_sel));
        check_value("fsm_disabled", 32'(1), 32'(fsm_disabled));
        check_value("fsm_training", 32'(0), 32'(fsm_training));
        check_value("ts1_gen4_s", 32'(0), 32'(ts1_gen4_s));
        check_value("ts2_gen4_s", 32'(0), 32'(ts2_gen4_s));
        check_value("c_read", 32'(0), 32'(c_read));
        check_value("gen_speed", 32'(GEN4), 32'(gen_speed));
        reset_n = 1'b1;
        // Without tdisabled_min the controller stays disabled
        repeat (6) tick();
        check_value("fsm_disabled held", 32'(1), 32'(fsm_disabled));
        check_value("c_read held low", 32'(0), 32'(c_read));
        report_test();

        for (int r = 0; r < NUM_ROWS; r++) begin
            cur_test    = row_name[r];
            test_errors = 0;
            run_row(r);
            return_to_disabled();
            report_test();
        end

        $display("Tests run %0d, failed %0d, errors %0d", NUM_ROWS + 1, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
